// ==== design/gpi_irpt_pkg.sv ====
`default_nettype none

package gpi_irpt_pkg;

    //////////////////////////////
    // Sizes and threshold
    //////////////////////////////

    localparam int CH_NUM    = 8;
    localparam int GPI_WIDTH = 8;

    // High time in clk cycles that makes a level event
    localparam int PULSE_THRESHOLD_CYCLES = 64;
    localparam int CNT_W = $clog2(PULSE_THRESHOLD_CYCLES + 1);
    localparam logic [CNT_W-1:0] THR_CNT = CNT_W'(PULSE_THRESHOLD_CYCLES);

    //////////////////////////////
    // Status address map
    //////////////////////////////

    // Channel n sits at BASE + n * STRIDE + LOW, i.e. 16'h(n+1)00C
    localparam logic [15:0] STS_ADDR_BASE   = 16'h1000;
    localparam logic [15:0] STS_ADDR_STRIDE = 16'h1000;
    localparam logic [15:0] STS_ADDR_LOW    = 16'h000C;

    //////////////////////////////
    // Shared types
    //////////////////////////////

    // One bit per input, grouped by channel
    typedef logic [CH_NUM-1:0][GPI_WIDTH-1:0] gpi_vec_t;

    typedef struct packed {
        gpi_vec_t lvl;
        gpi_vec_t fall;
    } gpi_sync_t;

    typedef struct packed {
        gpi_vec_t level_hit;
        gpi_vec_t pulse_hit;
    } gpi_hit_t;

    // Level status in 7:0, pulse status in 15:8
    typedef struct packed {
        logic [15:0]          rsvd;
        logic [GPI_WIDTH-1:0] pulse;
        logic [GPI_WIDTH-1:0] level;
    } sts_word_t;

    typedef sts_word_t [CH_NUM-1:0] sts_array_t;

    typedef struct packed {
        logic [15:0] addr;
    } rd_req_t;

    typedef struct packed {
        sts_word_t data;
        logic      err;
    } rd_rsp_t;

    typedef enum logic {
        RD_IDLE,
        RD_RESP
    } rd_state_t;

endpackage

`default_nettype wire

// ==== design/gpi_input_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpi_input_sync
    import gpi_irpt_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire gpi_vec_t gpi,
    output gpi_sync_t     sync
);

    //////////////////////////////
    // Synchronizer chain
    //////////////////////////////

    // First stage may go metastable
    gpi_vec_t meta_q;
    // Settled level, two cycles behind the pins
    gpi_vec_t sync_q;
    // Level one cycle older, for edge detect
    gpi_vec_t prev_q;
    // Registered falling edge flags
    gpi_vec_t fall_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            meta_q <= '0;
            sync_q <= '0;
            prev_q <= '0;
            fall_q <= '0;
        end else begin
            meta_q <= gpi;
            sync_q <= meta_q;
            prev_q <= sync_q;
            // High last cycle, low now
            fall_q <= prev_q & ~sync_q;
        end
    end

    //////////////////////////////
    // Outputs
    //////////////////////////////

    // fall lands one cycle after lvl has already dropped
    assign sync = '{lvl: sync_q, fall: fall_q};

endmodule

`default_nettype wire

// ==== design/gpi_width_classify.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpi_width_classify
    import gpi_irpt_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire gpi_sync_t sync,
    output gpi_hit_t       hit
);

    //////////////////////////////
    // High time counters
    //////////////////////////////

    // One saturating counter per input bit
    logic [CNT_W-1:0] cnt_q [CH_NUM][GPI_WIDTH];

    // Counter sits at the threshold
    gpi_vec_t at_thr;
    // Same, one cycle later
    gpi_vec_t at_thr_q;

    gpi_vec_t level_hit_q;
    gpi_vec_t pulse_hit_q;

    always_comb begin
        for (int c = 0; c < CH_NUM; c++) begin
            for (int b = 0; b < GPI_WIDTH; b++) begin
                at_thr[c][b] = (cnt_q[c][b] == THR_CNT);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int c = 0; c < CH_NUM; c++) begin
                for (int b = 0; b < GPI_WIDTH; b++) begin
                    cnt_q[c][b] <= '0;
                end
            end
        end else begin
            for (int c = 0; c < CH_NUM; c++) begin
                for (int b = 0; b < GPI_WIDTH; b++) begin
                    if (!sync.lvl[c][b]) begin
                        cnt_q[c][b] <= '0;
                    end else if (!at_thr[c][b]) begin
                        cnt_q[c][b] <= cnt_q[c][b] + 1'b1;
                    end
                end
            end
        end
    end

    //////////////////////////////
    // Event strobes
    //////////////////////////////

    // At the fall cycle the counter is already cleared, but at_thr_q
    // still tells whether the high period that just ended was long
    always_ff @(posedge clk) begin
        if (rst) begin
            at_thr_q    <= '0;
            level_hit_q <= '0;
            pulse_hit_q <= '0;
        end else begin
            at_thr_q    <= at_thr;
            // First cycle at the threshold only
            level_hit_q <= at_thr & ~at_thr_q;
            pulse_hit_q <= sync.fall & ~at_thr_q;
        end
    end

    assign hit = '{level_hit: level_hit_q, pulse_hit: pulse_hit_q};

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Relies on the sync stage putting fall one cycle after lvl drops
    ap_hit_exclusive : assert property (
        @(posedge clk) disable iff (rst)
        (hit.level_hit & hit.pulse_hit) == '0
    );

endmodule

`default_nettype wire

// ==== design/gpi_status_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpi_status_bank
    import gpi_irpt_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire gpi_hit_t          hit,
    input  wire logic [CH_NUM-1:0] ch_clr,
    input  wire gpi_vec_t          irpt_mode,
    input  wire gpi_vec_t          irpt_en,
    output sts_array_t             sts,
    output logic                   irq
);

    //////////////////////////////
    // Sticky status
    //////////////////////////////

    gpi_vec_t lvl_sts_q;
    gpi_vec_t pls_sts_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            lvl_sts_q <= '0;
            pls_sts_q <= '0;
        end else begin
            for (int c = 0; c < CH_NUM; c++) begin
                // Clear first, then OR in new hits so a same-cycle event survives
                lvl_sts_q[c] <= (lvl_sts_q[c] & {GPI_WIDTH{~ch_clr[c]}})
                              | hit.level_hit[c];
                pls_sts_q[c] <= (pls_sts_q[c] & {GPI_WIDTH{~ch_clr[c]}})
                              | hit.pulse_hit[c];
            end
        end
    end

    // Status words as seen by the read port
    always_comb begin
        for (int c = 0; c < CH_NUM; c++) begin
            sts[c] = '{
                rsvd:  '0,
                pulse: pls_sts_q[c],
                level: lvl_sts_q[c]
            };
        end
    end

    //////////////////////////////
    // Interrupt
    //////////////////////////////

    // Mode 1 picks pulse status, mode 0 picks level status
    gpi_vec_t irq_src;

    always_comb begin
        irq_src = ((irpt_mode & pls_sts_q) | (~irpt_mode & lvl_sts_q)) & irpt_en;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            irq <= 1'b0;
        end else begin
            irq <= |irq_src;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Read port clears at most one channel per transfer
    ap_clr_onehot : assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(ch_clr)
    );

    // Clear is a single-cycle strobe, one read in flight at a time
    ap_clr_pulse : assert property (
        @(posedge clk) disable iff (rst)
        (ch_clr != '0) |=> (ch_clr == '0)
    );

endmodule

`default_nettype wire

// ==== design/gpi_read_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpi_read_port
    import gpi_irpt_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              req_valid,
    output logic                   req_ready,
    input  wire rd_req_t           req,
    output logic                   rsp_valid,
    input  wire logic              rsp_ready,
    output rd_rsp_t                rsp,
    input  wire sts_array_t        sts,
    output logic [CH_NUM-1:0]      ch_clr
);

    rd_state_t state;

    logic              req_xfer;
    logic              rsp_xfer;
    logic              off_ok;
    logic              ch_ok;
    logic [CH_NUM-1:0] ch_hot;
    sts_word_t         sel_word;

    assign req_ready = (state == RD_IDLE);
    assign rsp_valid = (state == RD_RESP);
    assign req_xfer  = req_valid && req_ready;
    assign rsp_xfer  = rsp_valid && rsp_ready;

    //////////////////////////////
    // Address decode
    //////////////////////////////

    always_comb begin
        logic [15:0] ch_addr;
        off_ok   = (req.addr[11:0] == STS_ADDR_LOW[11:0]);
        ch_hot   = '0;
        sel_word = '0;
        for (int n = 0; n < CH_NUM; n++) begin
            ch_addr   = STS_ADDR_BASE + 16'(n) * STS_ADDR_STRIDE + STS_ADDR_LOW;
            // Top nibble carries channel number plus one
            ch_hot[n] = off_ok && (req.addr[15:12] == ch_addr[15:12]);
            if (ch_hot[n]) begin
                sel_word = sts[n];
            end
        end
        ch_ok = |ch_hot;
    end

    // Clear goes out with the request, status drops on the same edge
    // that captures the response
    assign ch_clr = req_xfer ? ch_hot : '0;

    //////////////////////////////
    // Response and FSM
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (req_xfer) begin
            rsp.data <= ch_ok ? sel_word : '0;
            rsp.err  <= ~ch_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RD_IDLE;
        end else begin
            unique case (state)
                RD_IDLE: if (req_xfer) state <= RD_RESP;
                RD_RESP: if (rsp_xfer) state <= RD_IDLE;
                default: state <= RD_IDLE;
            endcase
        end
    end

    // Stalled response must not change
    ap_rsp_stable : assert property (
        @(posedge clk) disable iff (rst)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp))
    );

    // No second request until the first response is gone
    ap_one_outstanding : assert property (
        @(posedge clk) disable iff (rst)
        req_xfer |=> (state == RD_RESP) && !req_ready
    );

endmodule

`default_nettype wire

// ==== design/gpi_irpt_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpi_irpt_top
    import gpi_irpt_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire gpi_vec_t gpi,
    input  wire gpi_vec_t irpt_mode,
    input  wire gpi_vec_t irpt_en,
    input  wire logic     req_valid,
    output logic          req_ready,
    input  wire rd_req_t  req,
    output logic          rsp_valid,
    input  wire logic     rsp_ready,
    output rd_rsp_t       rsp,
    output logic          irq
);

    //////////////////////////////
    // Stage links
    //////////////////////////////

    gpi_sync_t         sync;
    gpi_hit_t          hit;
    sts_array_t        sts;
    logic [CH_NUM-1:0] ch_clr;

    gpi_input_sync u_sync (
        .clk  (clk),
        .rst  (rst),
        .gpi  (gpi),
        .sync (sync)
    );

    gpi_width_classify u_classify (
        .clk  (clk),
        .rst  (rst),
        .sync (sync),
        .hit  (hit)
    );

    gpi_status_bank u_status (
        .clk       (clk),
        .rst       (rst),
        .hit       (hit),
        .ch_clr    (ch_clr),
        .irpt_mode (irpt_mode),
        .irpt_en   (irpt_en),
        .sts       (sts),
        .irq       (irq)
    );

    // Host side, also feeds clears back to the status bank
    gpi_read_port u_read (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp),
        .sts       (sts),
        .ch_clr    (ch_clr)
    );

endmodule

`default_nettype wire

// ==== bench/gpi_irpt_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpi_irpt_tb
    import gpi_irpt_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int NUM_ROUNDS   = 40;
    localparam int QUIET        = 16;
    localparam int SHORT_MAX    = PULSE_THRESHOLD_CYCLES - 8;
    localparam int LONG_MIN     = PULSE_THRESHOLD_CYCLES + 8;
    localparam int LONG_SPAN    = 40;
    localparam int READ_MAX     = 64;
    // Worst round is three events and nine reads
    localparam int ROUND_CYCLES = 3 * (LONG_MIN + LONG_SPAN + QUIET + 2) + 9 * READ_MAX;
    localparam int TOTAL_ROUNDS = NUM_ROUNDS + 16;
    localparam longint WATCHDOG_NS = longint'(TOTAL_ROUNDS) * ROUND_CYCLES * CLK_PERIOD * 2;

    logic     clk;
    logic     rst;
    gpi_vec_t gpi;
    gpi_vec_t irpt_mode;
    gpi_vec_t irpt_en;
    logic     req_valid;
    logic     req_ready;
    rd_req_t  req;
    logic     rsp_valid;
    logic     rsp_ready;
    rd_rsp_t  rsp;
    logic     irq;

    // Reference status, one byte of level and one of pulse per channel
    logic [GPI_WIDTH-1:0] mdl_lvl [CH_NUM];
    logic [GPI_WIDTH-1:0] mdl_pls [CH_NUM];
    integer seed;

    gpi_irpt_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .gpi       (gpi),
        .irpt_mode (irpt_mode),
        .irpt_en   (irpt_en),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp),
        .irq       (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the test did not finish within %0d ns", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $fatal(1);
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [15:0] chan_addr(input int ch);
        return {4'(ch + 1), 12'h00C};
    endfunction

    function automatic logic addr_in_map(input logic [15:0] a);
        return a[11:0] == 12'h00C && a[15:12] >= 4'd1 && a[15:12] <= 4'(CH_NUM);
    endfunction

    function automatic logic [31:0] model_word(input int ch);
        return {16'h0000, mdl_pls[ch], mdl_lvl[ch]};
    endfunction

    // Mode 1 takes pulse status, mode 0 takes level status
    function automatic logic model_irq();
        logic r;
        r = 1'b0;
        for (int c = 0; c < CH_NUM; c++) begin
            for (int b = 0; b < GPI_WIDTH; b++) begin
                if (irpt_en[c][b]) begin
                    r = r | (irpt_mode[c][b] ? mdl_pls[c][b] : mdl_lvl[c][b]);
                end
            end
        end
        return r;
    endfunction

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // Drive point sits just after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_event(input int ch, input int b, input logic long_high);
        int len;
        len = long_high ? LONG_MIN + rand_below(LONG_SPAN) : 1 + rand_below(SHORT_MAX);
        gpi[ch][b] = 1'b1;
        repeat (len) next_cycle();
        gpi[ch][b] = 1'b0;
        repeat (QUIET) next_cycle();
        if (long_high) mdl_lvl[ch][b] = 1'b1;
        else mdl_pls[ch][b] = 1'b1;
    endtask

    task automatic random_event();
        drive_event(rand_below(CH_NUM), rand_below(GPI_WIDTH), rand_below(2) == 1);
    endtask

    task automatic read_status(input logic [15:0] addr, input logic [31:0] exp_data,
                               input logic exp_err);
        rd_rsp_t held;
        logic    first;
        req_valid = 1'b1;
        req.addr  = addr;
        @(negedge clk);
        while (!req_ready) begin
            next_cycle();
            @(negedge clk);
        end
        next_cycle();
        req_valid = 1'b0;
        rsp_ready = rand_below(2) == 1;
        first = 1'b1;
        forever begin
            @(negedge clk);
            if (first) held = rsp;
            first = 1'b0;
            check(64'(rsp_valid), 64'd1, "response valid while pending");
            check(64'(req_ready), 64'd0, "req_ready low while response pending");
            check(64'(rsp), 64'(held), "response stable under back-pressure");
            if (rsp_ready) break;
            next_cycle();
            rsp_ready = rand_below(2) == 1;
        end
        check(64'(rsp.data), 64'(exp_data), "read data");
        check(64'(rsp.err), 64'(exp_err), "read error flag");
        next_cycle();
        rsp_ready = 1'b0;
    endtask

    task automatic read_channel(input int ch);
        read_status(chan_addr(ch), model_word(ch), 1'b0);
        mdl_lvl[ch] = '0;
        mdl_pls[ch] = '0;
    endtask

    task automatic check_irq();
        repeat (2) next_cycle();
        @(negedge clk);
        check(64'(irq), 64'(model_irq()), "irq against model");
        next_cycle();
    endtask

    task automatic randomize_config();
        irpt_mode = {$random(seed), $random(seed)};
        irpt_en   = {$random(seed), $random(seed)};
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        int          ch;
        logic [15:0] bad;
        seed      = 32'hc29e;
        rst       = 1'b1;
        gpi       = '0;
        irpt_mode = '0;
        irpt_en   = '0;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b0;
        for (int c = 0; c < CH_NUM; c++) begin
            mdl_lvl[c] = '0;
            mdl_pls[c] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        // Idle state after reset
        @(negedge clk);
        check(64'(irq), 64'd0, "irq after reset");
        check(64'(req_ready), 64'd1, "req_ready after reset");
        check(64'(rsp_valid), 64'd0, "rsp_valid after reset");
        next_cycle();
        for (int c = 0; c < CH_NUM; c++) read_channel(c);

        // Long and short highs, each read twice
        for (int i = 0; i < 8; i++) begin
            ch = rand_below(CH_NUM);
            drive_event(ch, rand_below(GPI_WIDTH), 1'b1);
            read_channel(ch);
            read_channel(ch);
            ch = rand_below(CH_NUM);
            drive_event(ch, rand_below(GPI_WIDTH), 1'b0);
            read_channel(ch);
            read_channel(ch);
        end

        // irq follows mode and enable, drops once all is read
        for (int i = 0; i < 2; i++) begin
            randomize_config();
            repeat (3) random_event();
            check_irq();
            for (int c = 0; c < CH_NUM; c++) read_channel(c);
            check_irq();
            check(64'(irq), 64'd0, "irq low after reading every channel");
        end

        // Unmapped addresses leave status alone
        ch = rand_below(CH_NUM);
        drive_event(ch, rand_below(GPI_WIDTH), 1'b1);
        repeat (8) begin
            bad = 16'($random(seed));
            if (rand_below(2) == 1) bad[11:0] = 12'h00C;
            while (addr_in_map(bad)) bad = 16'($random(seed));
            read_status(bad, 32'h0, 1'b1);
        end
        read_channel(ch);

        for (int r = 0; r < NUM_ROUNDS; r++) begin
            randomize_config();
            repeat (1 + rand_below(3)) random_event();
            check_irq();
            repeat (1 + rand_below(3)) read_channel(rand_below(CH_NUM));
            check_irq();
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== gpi_irpt.f ====
design/gpi_irpt_pkg.sv
design/gpi_input_sync.sv
design/gpi_width_classify.sv
design/gpi_status_bank.sv
design/gpi_read_port.sv
design/gpi_irpt_top.sv
bench/gpi_irpt_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := gpi_irpt_tb
FILELIST  := gpi_irpt.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, pass if SIMULATION PASSED is printed"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
